// File: src/noc_pkg.sv
`default_nettype none

package noc_pkg;

  localparam int flit_data_width       = 36;
  localparam int id_width              = 4;
  localparam int tag_width             = 4;
  localparam int vc_width              = 2;
  localparam int request_header_flits  = 2;
  localparam int response_header_flits = 1;
  localparam int fifo_depth            = 4;

  // a request header is the longest, so it sets the size of the header image
  localparam int header_image_width    = request_header_flits * flit_data_width;
  localparam int header_count_width    = $clog2(request_header_flits);
  localparam int fifo_ptr_width        = $clog2(fifo_depth);
  localparam int fifo_count_width      = $clog2(fifo_depth + 1);

  typedef enum logic {
    header_flit,
    payload_flit
  } flit_type_e;

  typedef enum logic [1:0] {
    read_request,
    write_request,
    read_response,
    write_response
  } packet_type_e;

  typedef enum logic [1:0] {
    okay,
    exokay,
    slave_error,
    decode_error
  } status_e;

  typedef struct packed {
    flit_type_e                 flit_type;
    logic                       head;
    logic                       tail;
    logic [flit_data_width-1:0] data;
  } flit_t;

  typedef struct packed {
    packet_type_e         packet_type;
    logic [id_width-1:0]  destination_id;
    logic [id_width-1:0]  source_id;
    logic [vc_width-1:0]  vc;
    logic [tag_width-1:0] tag;
    logic [7:0]           burst_length;
    logic [31:0]          address;
    status_e              status;
  } packet_header_t;

  // field order puts packet_type in the top bits of the first flit
  typedef struct packed {
    packet_type_e         packet_type;
    logic [id_width-1:0]  destination_id;
    logic [id_width-1:0]  source_id;
    logic [vc_width-1:0]  vc;
    logic [tag_width-1:0] tag;
    logic [7:0]           burst_length_minus_one;
    logic [31:0]          address;
  } request_header_t;

  typedef struct packed {
    packet_type_e         packet_type;
    logic [id_width-1:0]  destination_id;
    logic [id_width-1:0]  source_id;
    logic [vc_width-1:0]  vc;
    logic [tag_width-1:0] tag;
    status_e              status;
  } response_header_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  byte_enable;
    status_e     status;
    logic        last;
    logic        response_last;
  } payload_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  byte_enable;
  } write_payload_t;

  typedef struct packed {
    logic [31:0] data;
    status_e     status;
    logic        response_last;
  } read_payload_t;

  function automatic logic is_request(input packet_type_e packet_type);
    return (packet_type == read_request) || (packet_type == write_request);
  endfunction

  function automatic logic has_payload(input packet_type_e packet_type);
    return (packet_type == write_request) || (packet_type == read_response);
  endfunction

  function automatic logic [header_count_width-1:0] last_header_index(
    input packet_type_e packet_type
  );
    if (is_request(packet_type)) begin
      return header_count_width'(request_header_flits - 1);
    end
    return header_count_width'(response_header_flits - 1);
  endfunction

endpackage

`default_nettype wire

// File: src/packet_packer.sv
`timescale 1ns/1ps
`default_nettype none

module packet_packer import noc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           header_valid,
  input  packet_header_t header,
  output logic           header_ready,
  input  logic           payload_valid,
  input  payload_t       payload,
  output logic           payload_ready,
  output logic           flit_valid,
  output flit_t          flit,
  input  logic           flit_ready
);

  flit_type_e                    current_flit;
  logic [header_count_width-1:0] header_count;
  logic                          last_header;
  logic                          flit_accepted;
  packet_type_e                  payload_packet_type;
  request_header_t               request_header;
  response_header_t              response_header;
  logic [header_image_width-1:0] header_image;
  flit_t                         header_flit_out;
  flit_t                         payload_flit_out;
  write_payload_t                write_payload;
  read_payload_t                 read_payload;

  assign request_header = '{
    packet_type:            header.packet_type,
    destination_id:         header.destination_id,
    source_id:              header.source_id,
    vc:                     header.vc,
    tag:                    header.tag,
    burst_length_minus_one: header.burst_length - 8'd1,
    address:                header.address
  };

  assign response_header = '{
    packet_type:    header.packet_type,
    destination_id: header.destination_id,
    source_id:      header.source_id,
    vc:             header.vc,
    tag:            header.tag,
    status:         header.status
  };

  // the header sits at the top of the image so flit 0 always carries packet_type
  assign header_image = is_request(header.packet_type) ?
    {request_header, {(header_image_width - $bits(request_header_t)){1'b0}}} :
    {response_header, {(header_image_width - $bits(response_header_t)){1'b0}}};

  assign last_header = (header_count == last_header_index(header.packet_type));

  always_comb begin
    header_flit_out.flit_type = header_flit;
    header_flit_out.head      = (header_count == '0);
    header_flit_out.tail      = last_header && !has_payload(header.packet_type);
    header_flit_out.data      =
      header_image[header_image_width - 1 - header_count * flit_data_width -: flit_data_width];
  end

  assign write_payload = '{data: payload.data, byte_enable: payload.byte_enable};
  assign read_payload  = '{
    data:          payload.data,
    status:        payload.status,
    response_last: payload.response_last
  };

  always_comb begin
    payload_flit_out.flit_type = payload_flit;
    payload_flit_out.head      = 1'b0;
    payload_flit_out.tail      = payload.last;
    if (payload_packet_type == write_request) begin
      payload_flit_out.data = write_payload;
    end else begin
      payload_flit_out.data =
        {{(flit_data_width - $bits(read_payload_t)){1'b0}}, read_payload};
    end
  end

  always_comb begin
    if (current_flit == header_flit) begin
      flit_valid = header_valid;
      flit       = header_flit_out;
    end else begin
      flit_valid = payload_valid;
      flit       = payload_flit_out;
    end
  end

  assign flit_accepted = flit_valid && flit_ready;
  // the header is consumed only together with its last flit
  assign header_ready  = (current_flit == header_flit) && flit_ready && last_header;
  assign payload_ready = (current_flit == payload_flit) && flit_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      current_flit        <= header_flit;
      header_count        <= '0;
      payload_packet_type <= read_request;
    end else if (flit_accepted) begin
      if (current_flit == header_flit) begin
        if (last_header) begin
          header_count        <= '0;
          payload_packet_type <= header.packet_type;
          if (has_payload(header.packet_type)) begin
            current_flit <= payload_flit;
          end
        end else begin
          header_count <= header_count + 1'b1;
        end
      end else if (payload.last) begin
        current_flit <= header_flit;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/flit_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module flit_buffer import noc_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  flit_t in_flit,
  output logic  in_ready,
  output logic  out_valid,
  output flit_t out_flit,
  input  logic  out_ready
);

  flit_t                       mem [fifo_depth];
  logic [fifo_ptr_width-1:0]   write_ptr;
  logic [fifo_ptr_width-1:0]   read_ptr;
  logic [fifo_count_width-1:0] count;
  logic                        full;
  logic                        push;
  logic                        pop;

  function automatic logic [fifo_ptr_width-1:0] next_ptr(input logic [fifo_ptr_width-1:0] ptr);
    if (ptr == fifo_ptr_width'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full      = (count == fifo_count_width'(fifo_depth));
  assign out_valid = (count != '0);
  assign out_flit  = mem[read_ptr];
  // a full buffer still takes a flit when the head leaves in the same cycle
  assign in_ready  = !full || out_ready;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[write_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      write_ptr <= '0;
      read_ptr  <= '0;
      count     <= '0;
    end else begin
      if (push) begin
        write_ptr <= next_ptr(write_ptr);
      end
      if (pop) begin
        read_ptr <= next_ptr(read_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/packet_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module packet_unpacker import noc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           flit_valid,
  input  flit_t          flit,
  output logic           flit_ready,
  output logic           header_valid,
  output packet_header_t header,
  input  logic           header_ready,
  output logic           payload_valid,
  output payload_t       payload,
  input  logic           payload_ready
);

  typedef enum logic [1:0] {
    collect_header,
    hold_header,
    stream_payload
  } unpacker_state_e;

  unpacker_state_e               state;
  logic [header_count_width-1:0] header_count;
  logic [header_image_width-1:0] header_image;
  packet_type_e                  packet_type_q;
  packet_type_e                  incoming_type;
  logic                          last_header;
  logic                          flit_accepted;
  request_header_t               request_header;
  response_header_t              response_header;
  write_payload_t                write_payload;
  read_payload_t                 read_payload;

  // the first header flit names the packet type before it is stored
  assign incoming_type = (header_count == '0) ?
    packet_type_e'(flit.data[flit_data_width-1 -: $bits(packet_type_e)]) : packet_type_q;
  assign last_header   = (header_count == last_header_index(incoming_type));

  always_comb begin
    case (state)
      collect_header: flit_ready = 1'b1;
      stream_payload: flit_ready = payload_ready;
      default:        flit_ready = 1'b0;
    endcase
  end

  assign flit_accepted = flit_valid && flit_ready;
  assign header_valid  = (state == hold_header);
  assign payload_valid = (state == stream_payload) && flit_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= collect_header;
      header_count  <= '0;
      packet_type_q <= read_request;
    end else begin
      case (state)
        collect_header: begin
          if (flit_accepted) begin
            packet_type_q <= incoming_type;
            if (last_header) begin
              header_count <= '0;
              state        <= hold_header;
            end else begin
              header_count <= header_count + 1'b1;
            end
          end
        end
        hold_header: begin
          if (header_ready) begin
            if (has_payload(packet_type_q)) begin
              state <= stream_payload;
            end else begin
              state <= collect_header;
            end
          end
        end
        stream_payload: begin
          if (flit_accepted && flit.tail) begin
            state <= collect_header;
          end
        end
        default: state <= collect_header;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == collect_header) && flit_accepted) begin
      header_image[header_image_width - 1 - header_count * flit_data_width -: flit_data_width]
        <= flit.data;
    end
  end

  assign request_header  = header_image[header_image_width-1 -: $bits(request_header_t)];
  assign response_header = header_image[header_image_width-1 -: $bits(response_header_t)];

  always_comb begin
    header             = '0;
    header.packet_type = packet_type_q;
    if (is_request(packet_type_q)) begin
      header.destination_id = request_header.destination_id;
      header.source_id      = request_header.source_id;
      header.vc             = request_header.vc;
      header.tag            = request_header.tag;
      header.burst_length   = request_header.burst_length_minus_one + 8'd1;
      header.address        = request_header.address;
      header.status         = okay;
    end else begin
      header.destination_id = response_header.destination_id;
      header.source_id      = response_header.source_id;
      header.vc             = response_header.vc;
      header.tag            = response_header.tag;
      header.status         = response_header.status;
    end
  end

  assign write_payload = flit.data;
  assign read_payload  = flit.data[$bits(read_payload_t)-1:0];

  // payload layout follows the packet type seen in the header
  always_comb begin
    payload      = '0;
    payload.last = flit.tail;
    if (packet_type_q == write_request) begin
      payload.data        = write_payload.data;
      payload.byte_enable = write_payload.byte_enable;
    end else begin
      payload.data          = read_payload.data;
      payload.status        = read_payload.status;
      payload.response_last = read_payload.response_last;
    end
  end

endmodule

`default_nettype wire

// File: src/noc_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module noc_link_top import noc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           source_header_valid,
  input  packet_header_t source_header,
  output logic           source_header_ready,
  input  logic           source_payload_valid,
  input  payload_t       source_payload,
  output logic           source_payload_ready,
  output logic           sink_header_valid,
  output packet_header_t sink_header,
  input  logic           sink_header_ready,
  output logic           sink_payload_valid,
  output payload_t       sink_payload,
  input  logic           sink_payload_ready
);

  logic  packer_flit_valid;
  flit_t packer_flit;
  logic  packer_flit_ready;
  logic  link_flit_valid;
  flit_t link_flit;
  logic  link_flit_ready;

  packet_packer u_packet_packer (
    .clk           (clk),
    .rst_n         (rst_n),
    .header_valid  (source_header_valid),
    .header        (source_header),
    .header_ready  (source_header_ready),
    .payload_valid (source_payload_valid),
    .payload       (source_payload),
    .payload_ready (source_payload_ready),
    .flit_valid    (packer_flit_valid),
    .flit          (packer_flit),
    .flit_ready    (packer_flit_ready)
  );

  // the buffer stands in for the physical link between the two nodes
  flit_buffer u_flit_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (packer_flit_valid),
    .in_flit   (packer_flit),
    .in_ready  (packer_flit_ready),
    .out_valid (link_flit_valid),
    .out_flit  (link_flit),
    .out_ready (link_flit_ready)
  );

  packet_unpacker u_packet_unpacker (
    .clk           (clk),
    .rst_n         (rst_n),
    .flit_valid    (link_flit_valid),
    .flit          (link_flit),
    .flit_ready    (link_flit_ready),
    .header_valid  (sink_header_valid),
    .header        (sink_header),
    .header_ready  (sink_header_ready),
    .payload_valid (sink_payload_valid),
    .payload       (sink_payload),
    .payload_ready (sink_payload_ready)
  );

endmodule

`default_nettype wire

// File: verif/noc_link_assert.sv
`timescale 1ns/1ps
`default_nettype none

module noc_link_assert import noc_pkg::*; (
  input logic                        clk,
  input logic                        rst_n,
  input logic [fifo_count_width-1:0] count,
  input logic                        in_valid,
  input flit_t                       in_flit,
  input logic                        out_valid,
  input flit_t                       out_flit,
  input logic                        out_ready
);

  int failure_count = 0;

  count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    count <= fifo_count_width'(fifo_depth))
  else begin
    $error("flit buffer count went above its depth");
    failure_count++;
  end

  // a stalled head flit must wait unchanged for the unpacker
  stalled_output_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_flit))
  else begin
    $error("flit buffer output changed while stalled");
    failure_count++;
  end

  head_is_header: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && in_flit.head |-> in_flit.flit_type == header_flit)
  else begin
    $error("head flag seen on a payload flit");
    failure_count++;
  end

endmodule

bind flit_buffer noc_link_assert u_noc_link_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .count     (count),
  .in_valid  (in_valid),
  .in_flit   (in_flit),
  .out_valid (out_valid),
  .out_flit  (out_flit),
  .out_ready (out_ready)
);

`default_nettype wire

// File: verif/tb_noc_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_noc_link import noc_pkg::*; ();

  localparam int clk_period    = 8;
  localparam int sample_delay  = 2;
  localparam int reset_cycles  = 16;
  localparam int idle_cycles   = 20;
  localparam int total_beats   = 16;
  localparam int total_packets = 9;
  // every beat and every packet gets enough cycles to cross a back-pressured link
  localparam int watchdog_cycles =
    reset_cycles + idle_cycles + 8 * (total_beats + 3 * total_packets) + 100;

  logic           clk;
  logic           rst_n;
  logic           source_header_valid;
  packet_header_t source_header;
  logic           source_header_ready;
  logic           source_payload_valid;
  payload_t       source_payload;
  logic           source_payload_ready;
  logic           sink_header_valid;
  packet_header_t sink_header;
  logic           sink_header_ready;
  logic           sink_payload_valid;
  payload_t       sink_payload;
  logic           sink_payload_ready;
  logic           back_pressure;
  logic [15:0]    data_lfsr;
  logic [15:0]    ready_lfsr;
  int             error_count;
  int             check_count;
  packet_header_t expected_headers[$];
  payload_t       expected_beats[$];

  noc_link_top u_noc_link_top (
    .clk                  (clk),
    .rst_n                (rst_n),
    .source_header_valid  (source_header_valid),
    .source_header        (source_header),
    .source_header_ready  (source_header_ready),
    .source_payload_valid (source_payload_valid),
    .source_payload       (source_payload),
    .source_payload_ready (source_payload_ready),
    .sink_header_valid    (sink_header_valid),
    .sink_header          (sink_header),
    .sink_header_ready    (sink_header_ready),
    .sink_payload_valid   (sink_payload_valid),
    .sink_payload         (sink_payload),
    .sink_payload_ready   (sink_payload_ready)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hb400;
    end
    return state >> 1;
  endfunction

  task automatic take_bits(inout logic [15:0] state, input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits[i] = state[0];
      state   = lfsr_step(state);
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic report_problem(input string what);
    error_count++;
    $display("%s at %0t", what, $time);
  endtask

  // requests carry no status on the link and responses carry no length or address
  function automatic packet_header_t expected_header(input packet_header_t sent);
    packet_header_t exp;
    exp = sent;
    if (sent.packet_type == read_request || sent.packet_type == write_request) begin
      exp.status = okay;
    end else begin
      exp.burst_length = '0;
      exp.address      = '0;
    end
    return exp;
  endfunction

  function automatic payload_t expected_beat(input packet_type_e kind, input payload_t sent);
    payload_t exp;
    exp      = '0;
    exp.data = sent.data;
    exp.last = sent.last;
    if (kind == write_request) begin
      exp.byte_enable = sent.byte_enable;
    end else begin
      exp.status        = sent.status;
      exp.response_last = sent.response_last;
    end
    return exp;
  endfunction

  // the task starts on a falling edge and returns on the falling edge after the transfer
  task automatic wait_source_accept(input logic is_header, output int cycles);
    logic accepted;
    accepted = 1'b0;
    cycles   = 0;
    while (!accepted) begin
      #sample_delay;
      accepted = is_header ? source_header_ready : source_payload_ready;
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic send_packet(input packet_header_t hdr);
    payload_t    beat;
    logic [31:0] bits;
    int          beat_count;
    int          header_flits;
    int          wait_cycles;
    beat_count   = 0;
    header_flits = response_header_flits;
    if (hdr.packet_type == write_request || hdr.packet_type == read_response) begin
      beat_count = hdr.burst_length;
    end
    if (hdr.packet_type == read_request || hdr.packet_type == write_request) begin
      header_flits = request_header_flits;
    end
    expected_headers.push_back(expected_header(hdr));
    source_header       = hdr;
    source_header_valid = 1'b1;
    wait_source_accept(1'b1, wait_cycles);
    // with the sink always ready the header leaves together with its last flit
    if (!back_pressure) begin
      check_value("source_header_ready", wait_cycles, header_flits);
    end
    source_header_valid = 1'b0;
    for (int i = 0; i < beat_count; i++) begin
      take_bits(data_lfsr, 32, bits);
      beat.data = bits;
      take_bits(data_lfsr, 7, bits);
      beat.byte_enable   = bits[3:0];
      beat.status        = status_e'(bits[5:4]);
      beat.last          = (i == beat_count - 1);
      beat.response_last = bits[6];
      expected_beats.push_back(expected_beat(hdr.packet_type, beat));
      source_payload       = beat;
      source_payload_valid = 1'b1;
      wait_source_accept(1'b0, wait_cycles);
      if (!back_pressure) begin
        check_value("source_payload_ready", wait_cycles, 1);
      end
    end
    source_payload_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (expected_headers.size() != 0 || expected_beats.size() != 0) begin
      @(negedge clk);
    end
    // a few quiet cycles catch any stray beat after the packet
    repeat (4) @(negedge clk);
  endtask

  task automatic test_idle_after_reset();
    repeat (idle_cycles) begin
      @(negedge clk);
      #sample_delay;
      check_value("sink_header_valid", sink_header_valid, 1'b0);
      check_value("sink_payload_valid", sink_payload_valid, 1'b0);
    end
    @(negedge clk);
  endtask

  task automatic test_single_packets();
    send_packet('{read_request, 4'ha, 4'h5, 2'd3, 4'hc, 8'd16, 32'hdead_beef, okay});
    wait_drained();
    send_packet('{write_request, 4'h3, 4'h9, 2'd1, 4'h7, 8'd4, 32'h8000_1234, okay});
    wait_drained();
    send_packet('{read_response, 4'h6, 4'h2, 2'd2, 4'h1, 8'd3, 32'h1111_2222, exokay});
    send_packet('{write_response, 4'hf, 4'h0, 2'd0, 4'he, 8'd0, 32'h0, slave_error});
    wait_drained();
  endtask

  task automatic test_back_pressure();
    @(posedge clk);
    back_pressure = 1'b1;
    @(negedge clk);
    send_packet('{write_request, 4'h1, 4'h8, 2'd2, 4'h3, 8'd4, 32'h0000_0040, okay});
    send_packet('{read_response, 4'h8, 4'h1, 2'd1, 4'h4, 8'd4, 32'h0, okay});
    send_packet('{read_request, 4'h2, 4'h7, 2'd0, 4'h5, 8'd8, 32'hffff_fffc, okay});
    wait_drained();
    @(posedge clk);
    back_pressure = 1'b0;
    @(negedge clk);
  endtask

  task automatic test_burst_limits();
    send_packet('{read_request, 4'h4, 4'hb, 2'd3, 4'hf, 8'd255, 32'h7654_3210, okay});
    send_packet('{write_request, 4'hb, 4'h4, 2'd1, 4'h0, 8'd1, 32'h0000_1000, okay});
    wait_drained();
  endtask

  initial begin
    logic [31:0] ready_bits;
    forever begin
      @(negedge clk);
      if (back_pressure) begin
        take_bits(ready_lfsr, 2, ready_bits);
        sink_header_ready  = ready_bits[0];
        sink_payload_ready = ready_bits[1];
      end else begin
        sink_header_ready  = 1'b1;
        sink_payload_ready = 1'b1;
      end
      #sample_delay;
      if (rst_n && sink_header_valid && sink_header_ready) begin
        if (expected_headers.size() == 0) begin
          report_problem("a header reached the sink with no packet outstanding");
        end else begin
          check_value("sink_header", sink_header, expected_headers.pop_front());
        end
      end
      if (rst_n && sink_payload_valid && sink_payload_ready) begin
        if (expected_beats.size() == 0) begin
          report_problem("a payload beat reached the sink with none outstanding");
        end else begin
          check_value("sink_payload", sink_payload, expected_beats.pop_front());
        end
      end
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles with packets still in flight",
             watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk                  = 1'b0;
    rst_n                = 1'b0;
    source_header_valid  = 1'b0;
    source_header        = '0;
    source_payload_valid = 1'b0;
    source_payload       = '0;
    sink_header_ready    = 1'b1;
    sink_payload_ready   = 1'b1;
    back_pressure        = 1'b0;
    data_lfsr            = 16'd31;
    ready_lfsr           = 16'd31;
    error_count          = 0;
    check_count          = 0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_idle_after_reset();
    test_single_packets();
    test_back_pressure();
    test_burst_limits();
    if (u_noc_link_top.u_flit_buffer.u_noc_link_assert.failure_count != 0) begin
      report_problem("flit buffer assertions failed during the run");
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
src/noc_pkg.sv
src/packet_packer.sv
src/flit_buffer.sv
src/packet_unpacker.sv
src/noc_link_top.sv
verif/noc_link_assert.sv
verif/tb_noc_link.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_noc_link
FILELIST  = compile.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
